// File: i2s_deci_rx.f
+incdir+include
source/i2s_deci_rx_pkg.sv
source/predeci_sample_writer.sv
source/predeci_sample_ram.sv
source/deci_sample_fifo.sv
source/i2s_deci_rx_top.sv
tb/tb_i2s_deci_rx.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the I2S decimation receive testbench with Verilator.
# The exit status is the simulator's own status.

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
    -f i2s_deci_rx.f \
    --top-module tb_i2s_deci_rx \
    -o sim_tb_i2s_deci_rx
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/sim_tb_i2s_deci_rx
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

exit 0

// File: tb/i2s_deci_rx_patterns.hex
// one 16-bit hex word per line
// 0-7 samples for addresses 0-7, 8-15 expected words after host clear
1a2b
c3d4
7f00
8001
0ff0
5a5a
a5a5
1234
// addresses 0-7 after clearing 2 and 5
1a2b
c3d4
0000
8001
0ff0
0000
a5a5
1234
// 16-17 samples strobed in clear mode, must not reach the RAM
dead
beef
// 18 sample written after clear mode ends
6c6c
// 19 write address after the clear mode strobes
0009
// 20 write address of the sample after clear mode
000a

// File: tb/tb_i2s_deci_rx.sv
// I2S decimation receive testbench
`timescale 1ns/1ps
`default_nettype none

`include "i2s_deci_rx_defines.svh"

module tb_i2s_deci_rx;

    localparam int wait_limit  = 16;
    localparam int drain_limit = `I2S_DECI_RX_FIFO_DEPTH + 8;

    logic                         WBs_CLK_i;
    logic                         WBs_RST_i;
    i2s_deci_rx_pkg::sample_t     predeci_sample_i;
    logic                         predeci_sample_wr_i;
    logic                         host_clear_mode_i;
    i2s_deci_rx_pkg::ram_addr_t   host_clear_addr_i;
    logic                         host_clear_wen_i;
    i2s_deci_rx_pkg::ram_addr_t   fir_rd_addr_i;
    i2s_deci_rx_pkg::sample_t     fir_rd_data_o;
    i2s_deci_rx_pkg::ram_addr_t   predeci_wr_addr_o;
    logic                         predeci_wr_en_o;
    i2s_deci_rx_pkg::sample_t     deci_sample_i;
    logic                         deci_push_i;
    logic                         deci_pop_i;
    logic                         deci_flush_i;
    i2s_deci_rx_pkg::sample_t     deci_data_o;
    logic                         deci_empty_o;
    logic                         deci_full_o;
    i2s_deci_rx_pkg::fifo_level_t deci_level_o;

    // directed words, layout in the hex file
    i2s_deci_rx_pkg::sample_t pat [0:20];
    // FIFO reference, oldest word at the front
    i2s_deci_rx_pkg::sample_t model [$];
    logic [31:0]              lfsr_q;

    i2s_deci_rx_top DUT (.*);

    // ------------------------------------------------------------
    // checks and helpers
    // ------------------------------------------------------------

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "testbench stopped at first error");
    endtask

    task automatic check_sample(input string name, input i2s_deci_rx_pkg::sample_t got,
                                input i2s_deci_rx_pkg::sample_t exp);
        if (got !== exp)
            stop_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_addr(input string name, input i2s_deci_rx_pkg::ram_addr_t got,
                              input i2s_deci_rx_pkg::ram_addr_t exp);
        if (got !== exp)
            stop_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_level(input string name, input i2s_deci_rx_pkg::fifo_level_t got,
                               input i2s_deci_rx_pkg::fifo_level_t exp);
        if (got !== exp)
            stop_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    // inputs change 1 ns after the edge
    task automatic next_cycle();
        @(posedge WBs_CLK_i);
        #1;
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one LFSR step per bit taken
    task automatic rand_sample(output i2s_deci_rx_pkg::sample_t w);
        for (int i = 0; i < `I2S_DECI_RX_SAMPLE_W; i++)
        begin
            lfsr_q = lfsr_next(lfsr_q);
            w = i2s_deci_rx_pkg::sample_t'({w, lfsr_q[31]});
        end
    endtask

    // ------------------------------------------------------------
    // sample buffer tasks
    // ------------------------------------------------------------

    task automatic write_sample(input i2s_deci_rx_pkg::sample_t s,
                                input i2s_deci_rx_pkg::ram_addr_t exp_addr);
        int n;
        predeci_sample_i    = s;
        predeci_sample_wr_i = 1'b1;
        next_cycle();
        predeci_sample_wr_i = 1'b0;
        // source moves on, writer must hold the word
        predeci_sample_i    = ~s;
        n = 0;
        while (!predeci_wr_en_o)
        begin
            if (n == wait_limit)
                stop_run("timeout waiting for the sample write enable");
            next_cycle();
            n++;
        end
        check_addr("predeci_wr_addr_o", predeci_wr_addr_o, exp_addr);
        next_cycle();
        // enable is a single-cycle pulse
        check_flag("predeci_wr_en_o", predeci_wr_en_o, 1'b0);
    endtask

    task automatic clear_mode_strobe(input i2s_deci_rx_pkg::sample_t s,
                                     input i2s_deci_rx_pkg::ram_addr_t exp_addr);
        int n;
        predeci_sample_i    = s;
        predeci_sample_wr_i = 1'b1;
        next_cycle();
        predeci_sample_wr_i = 1'b0;
        n = 0;
        while (predeci_wr_addr_o !== exp_addr)
        begin
            if (n == wait_limit)
                stop_run("timeout waiting for the write address to advance in clear mode");
            next_cycle();
            n++;
        end
        // counter moves but RAM never sees it
        check_flag("predeci_wr_en_o", predeci_wr_en_o, 1'b0);
        next_cycle();
        check_flag("predeci_wr_en_o", predeci_wr_en_o, 1'b0);
    endtask

    task automatic clear_word(input i2s_deci_rx_pkg::ram_addr_t a);
        host_clear_addr_i = a;
        host_clear_wen_i  = 1'b1;
        next_cycle();
        check_flag("predeci_wr_en_o", predeci_wr_en_o, 1'b1);
        host_clear_wen_i  = 1'b0;
    endtask

    // address sampled on one edge, word valid after it
    task automatic read_check(input i2s_deci_rx_pkg::ram_addr_t a,
                              input i2s_deci_rx_pkg::sample_t exp);
        fir_rd_addr_i = a;
        next_cycle();
        check_sample("fir_rd_data_o", fir_rd_data_o, exp);
    endtask

    // ------------------------------------------------------------
    // FIFO tasks
    // ------------------------------------------------------------

    task automatic fifo_op(input logic push, input logic pop, input logic flush,
                           input i2s_deci_rx_pkg::sample_t data);
        logic push_ok;
        logic pop_ok;
        push_ok = push && (model.size() < `I2S_DECI_RX_FIFO_DEPTH);
        pop_ok  = pop && (model.size() > 0);
        // fall-through word before any pop
        if (model.size() > 0)
            check_sample("deci_data_o", deci_data_o, model[0]);
        deci_push_i   = push;
        deci_pop_i    = pop;
        deci_flush_i  = flush;
        deci_sample_i = data;
        next_cycle();
        deci_push_i   = 1'b0;
        deci_pop_i    = 1'b0;
        deci_flush_i  = 1'b0;
        // flush wins over both handshakes
        if (flush)
        begin
            model.delete();
        end
        else
        begin
            if (pop_ok)
                void'(model.pop_front());
            if (push_ok)
                model.push_back(data);
        end
        check_level("deci_level_o", deci_level_o, i2s_deci_rx_pkg::fifo_level_t'(model.size()));
        check_flag("deci_empty_o", deci_empty_o, model.size() == 0);
        check_flag("deci_full_o", deci_full_o, model.size() == `I2S_DECI_RX_FIFO_DEPTH);
    endtask

    task automatic drain_fifo();
        int n;
        n = 0;
        while (!deci_empty_o)
        begin
            if (n == drain_limit)
                stop_run("timeout waiting for the FIFO to drain");
            fifo_op(1'b0, 1'b1, 1'b0, '0);
            n++;
        end
        check_level("deci_level_o", deci_level_o, '0);
    endtask

    // ------------------------------------------------------------
    // clock and test sequence
    // ------------------------------------------------------------

    initial
    begin
        WBs_CLK_i = 1'b0;
        forever #5 WBs_CLK_i = ~WBs_CLK_i;
    end

    initial
    begin
        i2s_deci_rx_pkg::sample_t w;
        WBs_RST_i           = 1'b1;
        predeci_sample_i    = '0;
        predeci_sample_wr_i = 1'b0;
        host_clear_mode_i   = 1'b0;
        host_clear_addr_i   = '0;
        host_clear_wen_i    = 1'b0;
        fir_rd_addr_i       = '0;
        deci_sample_i       = '0;
        deci_push_i         = 1'b0;
        deci_pop_i          = 1'b0;
        deci_flush_i        = 1'b0;
        lfsr_q              = 32'hdb94861d;
        $readmemh("tb/i2s_deci_rx_patterns.hex", pat);
        repeat (4) @(posedge WBs_CLK_i);
        #1;
        WBs_RST_i = 1'b0;

        // reset state
        check_addr("predeci_wr_addr_o", predeci_wr_addr_o, 9'd511);
        check_flag("predeci_wr_en_o", predeci_wr_en_o, 1'b0);
        check_flag("deci_empty_o", deci_empty_o, 1'b1);
        check_flag("deci_full_o", deci_full_o, 1'b0);
        check_level("deci_level_o", deci_level_o, '0);

        // eight strobed samples, then read back
        for (int i = 0; i < 8; i++)
            write_sample(pat[i], i2s_deci_rx_pkg::ram_addr_t'(i));
        for (int i = 0; i < 8; i++)
            read_check(i2s_deci_rx_pkg::ram_addr_t'(i), pat[i]);

        // host clear of 2 and 5, and 8 and 9 as strobe targets
        host_clear_mode_i = 1'b1;
        clear_word(9'd2);
        clear_word(9'd5);
        clear_word(9'd8);
        clear_word(9'd9);
        clear_mode_strobe(pat[16], 9'd8);
        clear_mode_strobe(pat[17], i2s_deci_rx_pkg::ram_addr_t'(pat[19]));
        host_clear_mode_i = 1'b0;
        for (int i = 0; i < 8; i++)
            read_check(i2s_deci_rx_pkg::ram_addr_t'(i), pat[8 + i]);
        read_check(9'd8, '0);
        read_check(9'd9, '0);
        write_sample(pat[18], i2s_deci_rx_pkg::ram_addr_t'(pat[20]));
        read_check(i2s_deci_rx_pkg::ram_addr_t'(pat[20]), pat[18]);

        // interleaved FIFO traffic
        fifo_op(1'b1, 1'b0, 1'b0, pat[0]);
        fifo_op(1'b1, 1'b0, 1'b0, pat[1]);
        fifo_op(1'b1, 1'b0, 1'b0, pat[2]);
        fifo_op(1'b0, 1'b1, 1'b0, '0);
        fifo_op(1'b1, 1'b1, 1'b0, pat[3]);
        check_level("deci_level_o", deci_level_o, 10'd2);
        fifo_op(1'b1, 1'b0, 1'b0, pat[4]);
        fifo_op(1'b1, 1'b0, 1'b0, pat[5]);
        fifo_op(1'b0, 1'b1, 1'b0, '0);
        fifo_op(1'b0, 1'b1, 1'b0, '0);
        fifo_op(1'b1, 1'b1, 1'b0, pat[6]);
        fifo_op(1'b1, 1'b0, 1'b0, pat[7]);
        drain_fifo();

        // fill to 512, one push too many, drain, one pop too many
        for (int i = 0; i < `I2S_DECI_RX_FIFO_DEPTH; i++)
        begin
            rand_sample(w);
            fifo_op(1'b1, 1'b0, 1'b0, w);
        end
        rand_sample(w);
        fifo_op(1'b1, 1'b0, 1'b0, w);
        drain_fifo();
        fifo_op(1'b0, 1'b1, 1'b0, '0);

        // flush beats a push and a pop in the same cycle
        for (int i = 0; i < 20; i++)
        begin
            rand_sample(w);
            fifo_op(1'b1, 1'b0, 1'b0, w);
        end
        rand_sample(w);
        fifo_op(1'b1, 1'b1, 1'b1, w);
        rand_sample(w);
        fifo_op(1'b1, 1'b0, 1'b0, w);
        check_sample("deci_data_o", deci_data_o, w);
        fifo_op(1'b0, 1'b1, 1'b0, '0);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: source/i2s_deci_rx_top.sv
// I2S decimation receive top
`timescale 1ns/1ps
`default_nettype none

module i2s_deci_rx_top
(
    // ------------------------------------------------------------
    // fabric clock and reset
    // ------------------------------------------------------------
    input  wire logic                       WBs_CLK_i,
    input  wire logic                       WBs_RST_i,

    // ------------------------------------------------------------
    // pre-decimation sample path
    // ------------------------------------------------------------

    // mono sample plus one-cycle strobe
    input  wire i2s_deci_rx_pkg::sample_t   predeci_sample_i,
    input  wire logic                       predeci_sample_wr_i,

    // host clear of chosen buffer words
    input  wire logic                       host_clear_mode_i,
    input  wire i2s_deci_rx_pkg::ram_addr_t host_clear_addr_i,
    input  wire logic                       host_clear_wen_i,

    // FIR read port, 1 cycle latency
    input  wire i2s_deci_rx_pkg::ram_addr_t fir_rd_addr_i,
    output i2s_deci_rx_pkg::sample_t        fir_rd_data_o,

    // counter address and applied write enable
    output i2s_deci_rx_pkg::ram_addr_t      predeci_wr_addr_o,
    output logic                            predeci_wr_en_o,

    // ------------------------------------------------------------
    // decimated sample FIFO
    // ------------------------------------------------------------
    input  wire i2s_deci_rx_pkg::sample_t   deci_sample_i,
    input  wire logic                       deci_push_i,
    input  wire logic                       deci_pop_i,
    input  wire logic                       deci_flush_i,

    output i2s_deci_rx_pkg::sample_t        deci_data_o,
    output logic                            deci_empty_o,
    output logic                            deci_full_o,
    output i2s_deci_rx_pkg::fifo_level_t    deci_level_o
);

    // writer to RAM, address and data
    // enable goes out through predeci_wr_en_o
    i2s_deci_rx_pkg::ram_addr_t ram_waddr;
    i2s_deci_rx_pkg::sample_t   ram_wdata;

    // sample counter, register stage and clear mux
    predeci_sample_writer u_predeci_sample_writer
    (
        .WBs_CLK_i          (WBs_CLK_i),
        .WBs_RST_i          (WBs_RST_i),
        .sample_i           (predeci_sample_i),
        .sample_wr_i        (predeci_sample_wr_i),
        .host_clear_mode_i  (host_clear_mode_i),
        .host_clear_wen_i   (host_clear_wen_i),
        .host_clear_addr_i  (host_clear_addr_i),
        .ram_waddr_o        (ram_waddr),
        .ram_wdata_o        (ram_wdata),
        .ram_wen_o          (predeci_wr_en_o),
        .wr_addr_o          (predeci_wr_addr_o)
    );

    // undecimated samples for the FIR engine
    predeci_sample_ram u_predeci_sample_ram
    (
        .WBs_CLK_i          (WBs_CLK_i),
        .waddr_i            (ram_waddr),
        .wdata_i            (ram_wdata),
        .wen_i              (predeci_wr_en_o),
        .raddr_i            (fir_rd_addr_i),
        .rdata_o            (fir_rd_data_o)
    );

    // decimated output samples
    deci_sample_fifo u_deci_sample_fifo
    (
        .WBs_CLK_i          (WBs_CLK_i),
        .WBs_RST_i          (WBs_RST_i),
        .flush_i            (deci_flush_i),
        .push_i             (deci_push_i),
        .push_data_i        (deci_sample_i),
        .pop_i              (deci_pop_i),
        .pop_data_o         (deci_data_o),
        .empty_o            (deci_empty_o),
        .full_o             (deci_full_o),
        .level_o            (deci_level_o)
    );

endmodule

`default_nettype wire

// File: source/deci_sample_fifo.sv
// Decimated sample FIFO
`timescale 1ns/1ps
`default_nettype none

`include "i2s_deci_rx_defines.svh"

module deci_sample_fifo
(
    // fabric clock and async reset
    input  wire logic                       WBs_CLK_i,
    input  wire logic                       WBs_RST_i,

    // sync flush that wins over push and pop
    input  wire logic                       flush_i,

    // producer side from the FIR output
    input  wire logic                       push_i,
    input  wire i2s_deci_rx_pkg::sample_t   push_data_i,

    // first-word fall-through consumer side
    input  wire logic                       pop_i,
    output i2s_deci_rx_pkg::sample_t        pop_data_o,

    // status
    output logic                            empty_o,
    output logic                            full_o,
    output i2s_deci_rx_pkg::fifo_level_t    level_o
);

    // ------------------------------------------------------------
    // local sizes and state
    // ------------------------------------------------------------

    // level value of a full FIFO
    localparam i2s_deci_rx_pkg::fifo_level_t level_full =
        i2s_deci_rx_pkg::fifo_level_t'(`I2S_DECI_RX_FIFO_DEPTH);

    // circular buffer storage
    i2s_deci_rx_pkg::sample_t fifo_mem [0:`I2S_DECI_RX_FIFO_DEPTH-1];

    // pointers wrap at 512 by their width
    logic [`I2S_DECI_RX_FIFO_AW-1:0] wr_ptr_q;
    logic [`I2S_DECI_RX_FIFO_AW-1:0] rd_ptr_q;

    i2s_deci_rx_pkg::fifo_level_t level_q;
    i2s_deci_rx_pkg::fifo_level_t level_nxt;

    // qualified handshakes
    logic push_ok;
    logic pop_ok;

    // ------------------------------------------------------------
    // flags and handshake qualify
    // ------------------------------------------------------------

    // both flags come straight off the level register
    assign empty_o = (level_q == '0);
    assign full_o  = (level_q == level_full);

    // push to full / pop from empty are dropped
    assign push_ok = push_i & ~full_o;
    assign pop_ok  = pop_i & ~empty_o;

    // ------------------------------------------------------------
    // level next state
    // ------------------------------------------------------------

    // flush is applied in the register block
    always_comb
    begin
        level_nxt = level_q;
        case ({push_ok, pop_ok})
            // push only adds one word
            2'b10:
            begin
                level_nxt = level_q + 1'b1;
            end
            // pop only removes one word
            2'b01:
            begin
                level_nxt = level_q - 1'b1;
            end
            // idle or push with pop holds the level
            default:
            begin
                level_nxt = level_q;
            end
        endcase
    end

    // ------------------------------------------------------------
    // pointers and level registers
    // ------------------------------------------------------------

    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            level_q  <= '0;
        end
        else if (flush_i)
        begin
            // back to empty on the next edge
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            level_q  <= '0;
        end
        else
        begin
            if (push_ok)
            begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_ok)
            begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            level_q <= level_nxt;
        end
    end

    // ------------------------------------------------------------
    // storage
    // ------------------------------------------------------------

    // write only on accepted push outside flush
    always_ff @(posedge WBs_CLK_i)
    begin
        if (push_ok && !flush_i)
        begin
            fifo_mem[wr_ptr_q] <= push_data_i;
        end
    end

    // oldest word shown whenever not empty
    assign pop_data_o = fifo_mem[rd_ptr_q];
    assign level_o    = level_q;

endmodule

`default_nettype wire

// File: source/predeci_sample_ram.sv
// Pre-decimation sample RAM
`timescale 1ns/1ps
`default_nettype none

`include "i2s_deci_rx_defines.svh"

module predeci_sample_ram
(
    // fabric clock, shared by both ports
    input  wire logic                       WBs_CLK_i,

    // write port from the sample writer
    input  wire i2s_deci_rx_pkg::ram_addr_t waddr_i,
    input  wire i2s_deci_rx_pkg::sample_t   wdata_i,
    input  wire logic                       wen_i,

    // FIR read port
    input  wire i2s_deci_rx_pkg::ram_addr_t raddr_i,
    output i2s_deci_rx_pkg::sample_t        rdata_o
);

    // ------------------------------------------------------------
    // storage
    // ------------------------------------------------------------

    // 512 x 16, contents undefined until written
    localparam int ram_depth = 1 << `I2S_DECI_RX_RAM_AW;

    i2s_deci_rx_pkg::sample_t sample_mem [0:ram_depth-1];
    i2s_deci_rx_pkg::sample_t rdata_q;

    // write lands on the edge after wen is seen
    always_ff @(posedge WBs_CLK_i)
    begin
        if (wen_i)
        begin
            sample_mem[waddr_i] <= wdata_i;
        end
    end

    // ------------------------------------------------------------
    // registered read
    // ------------------------------------------------------------

    // one cycle latency
    // same-address collision returns old word
    always_ff @(posedge WBs_CLK_i)
    begin
        rdata_q <= sample_mem[raddr_i];
    end

    assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: source/predeci_sample_writer.sv
// Pre-decimation sample writer
`timescale 1ns/1ps
`default_nettype none

module predeci_sample_writer
(
    // fabric clock and async reset
    input  wire logic                       WBs_CLK_i,
    input  wire logic                       WBs_RST_i,

    // mono sample and its one-cycle strobe
    input  wire i2s_deci_rx_pkg::sample_t   sample_i,
    input  wire logic                       sample_wr_i,

    // host clear controls
    input  wire logic                       host_clear_mode_i,
    input  wire logic                       host_clear_wen_i,
    input  wire i2s_deci_rx_pkg::ram_addr_t host_clear_addr_i,

    // single RAM write port
    output i2s_deci_rx_pkg::ram_addr_t      ram_waddr_o,
    output i2s_deci_rx_pkg::sample_t        ram_wdata_o,
    output logic                            ram_wen_o,

    // auto-increment counter value
    output i2s_deci_rx_pkg::ram_addr_t      wr_addr_o
);

    // ------------------------------------------------------------
    // sample side registers
    // ------------------------------------------------------------

    // counter starts at 511 so first sample goes to 0
    i2s_deci_rx_pkg::ram_addr_t wr_addr_q;
    logic                       wr_en_q;
    // sample held for the write cycle after the strobe
    i2s_deci_rx_pkg::sample_t   wr_data_q;

    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            wr_addr_q <= '1;
            wr_en_q   <= 1'b0;
        end
        else
        begin
            // wraps 511 -> 0 by width
            if (sample_wr_i)
            begin
                wr_addr_q <= wr_addr_q + 1'b1;
            end
            // exactly one cycle per strobe
            wr_en_q <= sample_wr_i;
        end
    end

    // payload only, captured with the strobe
    always_ff @(posedge WBs_CLK_i)
    begin
        if (sample_wr_i)
        begin
            wr_data_q <= sample_i;
        end
    end

    // ------------------------------------------------------------
    // write port mux
    // ------------------------------------------------------------

    // host clear owns the port and writes zeros
    assign ram_waddr_o = host_clear_mode_i ? host_clear_addr_i : wr_addr_q;
    assign ram_wdata_o = host_clear_mode_i ? '0 : wr_data_q;
    // strobes in clear mode move the counter only
    assign ram_wen_o   = host_clear_mode_i ? host_clear_wen_i : wr_en_q;

    assign wr_addr_o   = wr_addr_q;

endmodule

`default_nettype wire

// File: source/i2s_deci_rx_pkg.sv
// I2S decimation receive types
`default_nettype none

`include "i2s_deci_rx_defines.svh"

package i2s_deci_rx_pkg;

    // ------------------------------------------------------------
    // shared data types
    // ------------------------------------------------------------

    // one audio sample, raw or decimated
    typedef logic [`I2S_DECI_RX_SAMPLE_W-1:0] sample_t;

    // word address into the pre-decimation buffer
    typedef logic [`I2S_DECI_RX_RAM_AW-1:0] ram_addr_t;

    // words held in the decimated FIFO, 0 to 512
    typedef logic [`I2S_DECI_RX_LEVEL_W-1:0] fifo_level_t;

endpackage

`default_nettype wire

// File: include/i2s_deci_rx_defines.svh
// I2S decimation receive sizes
`ifndef I2S_DECI_RX_DEFINES_SVH
`define I2S_DECI_RX_DEFINES_SVH

// ------------------------------------------------------------
// sample path
// ------------------------------------------------------------

// audio sample width, before and after decimation
`define I2S_DECI_RX_SAMPLE_W 16

// pre-decimation buffer address width, 512 words
`define I2S_DECI_RX_RAM_AW 9

// ------------------------------------------------------------
// decimated sample FIFO
// ------------------------------------------------------------

// pointer width and matching depth
`define I2S_DECI_RX_FIFO_AW 9
`define I2S_DECI_RX_FIFO_DEPTH 512

// one extra bit so a full FIFO reads 512
`define I2S_DECI_RX_LEVEL_W 10

`endif
